//--- logic/flush_pkg.sv
`default_nettype none

package flush_pkg;

    // --------------------
    // One-hot flush events
    // --------------------
    localparam int EV_W          = 8;
    localparam int EV_MISPREDICT = 0;
    localparam int EV_FENCE      = 1;
    localparam int EV_FENCE_I    = 2;
    localparam int EV_SFENCE_VMA = 3;
    localparam int EV_FENCE_T    = 4;
    localparam int EV_CSR_FLUSH  = 5;
    localparam int EV_EXCEPTION  = 6;
    localparam int EV_ERET       = 7;

    // Committed instruction classes
    localparam int OP_W = 4;
    localparam logic [OP_W-1:0] OP_NONE        = 4'd0;
    localparam logic [OP_W-1:0] OP_BRANCH_MISS = 4'd1;
    localparam logic [OP_W-1:0] OP_FENCE       = 4'd2;
    localparam logic [OP_W-1:0] OP_FENCE_I     = 4'd3;
    localparam logic [OP_W-1:0] OP_SFENCE      = 4'd4;
    localparam logic [OP_W-1:0] OP_FENCE_T     = 4'd5;
    localparam logic [OP_W-1:0] OP_CSR_WR      = 4'd6;
    localparam logic [OP_W-1:0] OP_EXC         = 4'd7;
    localparam logic [OP_W-1:0] OP_ERET        = 4'd8;

    // --------------------
    // Sizes
    // --------------------
    localparam int FENCE_T_W    = 14;
    localparam int QUEUE_DEPTH  = 4;
    localparam int QUEUE_PTR_W  = 2;
    localparam int DCACHE_LINES = 8;
    // Line index width for the flush walk
    localparam int DCACHE_IDX_W = $clog2(DCACHE_LINES);

endpackage

`default_nettype wire

//--- logic/commit_event_decoder.sv
`default_nettype none

module commit_event_decoder import flush_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 commit_valid_i,
    input  logic [OP_W-1:0]      commit_op_i,
    input  logic [FENCE_T_W-1:0] commit_fence_t_i,
    input  logic                 full_i,
    output logic                 push_o,
    output logic [EV_W-1:0]      event_o,
    output logic [FENCE_T_W-1:0] mask_o
);

    logic [EV_W-1:0]      event_d;
    logic [FENCE_T_W-1:0] mask_d;
    logic                 known;

    // --------------------
    // Opcode to event
    // --------------------
    always_comb begin
        event_d = '0;
        mask_d  = '0;
        known   = 1'b1;
        case (commit_op_i)
            OP_BRANCH_MISS: event_d[EV_MISPREDICT] = 1'b1;
            OP_FENCE:       event_d[EV_FENCE]      = 1'b1;
            OP_FENCE_I:     event_d[EV_FENCE_I]    = 1'b1;
            OP_SFENCE:      event_d[EV_SFENCE_VMA] = 1'b1;
            OP_FENCE_T: begin
                event_d[EV_FENCE_T] = 1'b1;
                // Only fence.t carries a mask
                mask_d = commit_fence_t_i;
            end
            OP_CSR_WR:      event_d[EV_CSR_FLUSH]  = 1'b1;
            OP_EXC:         event_d[EV_EXCEPTION]  = 1'b1;
            OP_ERET:        event_d[EV_ERET]       = 1'b1;
            // OP_NONE and unused codes push nothing
            default:        known = 1'b0;
        endcase
    end

    // Push strobe, dropped when the queue reports full
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            push_o <= 1'b0;
        end else begin
            push_o <= commit_valid_i && known && !full_i;
        end
    end

    // Event payload, only meaningful with push_o
    always_ff @(posedge clk_i) begin
        event_o <= event_d;
        mask_o  <= mask_d;
    end

endmodule

`default_nettype wire

//--- logic/flush_event_queue.sv
`default_nettype none

module flush_event_queue import flush_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 push_i,
    input  logic [EV_W-1:0]      event_i,
    input  logic [FENCE_T_W-1:0] mask_i,
    input  logic                 halt_i,
    output logic [EV_W-1:0]      head_event_o,
    output logic [FENCE_T_W-1:0] head_mask_o,
    output logic                 head_valid_o,
    output logic                 full_o
);

    logic [EV_W-1:0]      ev_mem   [QUEUE_DEPTH];
    logic [FENCE_T_W-1:0] mask_mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] rd_ptr_q, wr_ptr_q;
    logic [QUEUE_PTR_W:0]   count_q;
    logic push_ok, pop;

    // Head is presented straight from storage
    assign head_valid_o = (count_q != '0);
    assign head_event_o = ev_mem[rd_ptr_q];
    assign head_mask_o  = mask_mem[rd_ptr_q];

    // Self pop, one cycle per event while the core runs
    assign pop     = head_valid_o && !halt_i;
    assign push_ok = push_i && ((count_q < QUEUE_DEPTH) || pop);

    // Counts the push already in the decoder register as occupied
    assign full_o = (({1'b0, count_q} + push_i) >= QUEUE_DEPTH);

    // --------------------
    // Pointers and count
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)     rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push_ok, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            ev_mem[wr_ptr_q]   <= event_i;
            mask_mem[wr_ptr_q] <= mask_i;
        end
    end

endmodule

`default_nettype wire

//--- logic/flush_controller.sv
`default_nettype none

module flush_controller import flush_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 event_valid_i,
    input  logic [EV_W-1:0]      event_i,
    input  logic [FENCE_T_W-1:0] fence_t_i,
    input  logic                 flush_dcache_ack_i,
    input  logic                 halt_csr_i,
    output logic                 set_pc_commit_o,
    output logic                 flush_if_o,
    output logic                 flush_unissued_instr_o,
    output logic                 flush_id_o,
    output logic                 flush_ex_o,
    output logic                 flush_bp_o,
    output logic                 flush_icache_o,
    output logic                 flush_tlb_o,
    output logic                 flush_dcache_lfsr_o,
    output logic                 flush_icache_lfsr_o,
    output logic                 flush_tlb_plru_tree_o,
    output logic                 flush_dcache_mem_arb_o,
    output logic                 flush_dcache_wbuffer_arb_o,
    output logic                 flush_dcache_fifo_o,
    output logic                 flush_dcache_o,
    output logic                 halt_o
);

    logic fence_active_d, fence_active_q;
    logic flush_dcache;
    logic ev_fire;

    // Head event is consumed only in a cycle the queue pops
    assign ev_fire = event_valid_i && !halt_o;

    // --------------------
    // Strobe decode
    // --------------------
    always_comb begin
        fence_active_d             = fence_active_q;
        flush_dcache               = 1'b0;
        set_pc_commit_o            = 1'b0;
        flush_if_o                 = 1'b0;
        flush_unissued_instr_o     = 1'b0;
        flush_id_o                 = 1'b0;
        flush_ex_o                 = 1'b0;
        flush_bp_o                 = 1'b0;
        flush_icache_o             = 1'b0;
        flush_tlb_o                = 1'b0;
        flush_dcache_lfsr_o        = 1'b0;
        flush_icache_lfsr_o        = 1'b0;
        flush_tlb_plru_tree_o      = 1'b0;
        flush_dcache_mem_arb_o     = 1'b0;
        flush_dcache_wbuffer_arb_o = 1'b0;
        flush_dcache_fifo_o        = 1'b0;

        if (ev_fire) begin
            // Mispredict only drops the front end
            if (event_i[EV_MISPREDICT]) begin
                flush_if_o             = 1'b1;
                flush_unissued_instr_o = 1'b1;
            end
            // Fence family and CSR writes restart from commit
            if (event_i[EV_FENCE] || event_i[EV_FENCE_I] ||
                event_i[EV_SFENCE_VMA] || event_i[EV_CSR_FLUSH]) begin
                set_pc_commit_o        = 1'b1;
                flush_if_o             = 1'b1;
                flush_unissued_instr_o = 1'b1;
                flush_id_o             = 1'b1;
                flush_ex_o             = 1'b1;
            end
            // Data cache is always written back on fence and fence.i
            if (event_i[EV_FENCE] || event_i[EV_FENCE_I]) begin
                flush_dcache   = 1'b1;
                fence_active_d = 1'b1;
            end
            if (event_i[EV_FENCE_I]) flush_icache_o = 1'b1;
            if (event_i[EV_SFENCE_VMA]) flush_tlb_o = 1'b1;

            // Fence.t, one strobe per mask bit
            if (event_i[EV_FENCE_T]) begin
                set_pc_commit_o            = 1'b1;
                flush_if_o                 = fence_t_i[0];
                flush_unissued_instr_o     = fence_t_i[1];
                flush_id_o                 = fence_t_i[2];
                flush_ex_o                 = fence_t_i[3];
                flush_dcache               = fence_t_i[4];
                flush_icache_o             = fence_t_i[5];
                flush_tlb_o                = fence_t_i[6];
                flush_bp_o                 = fence_t_i[7];
                flush_dcache_lfsr_o        = fence_t_i[8];
                flush_icache_lfsr_o        = fence_t_i[9];
                flush_tlb_plru_tree_o      = fence_t_i[10];
                flush_dcache_mem_arb_o     = fence_t_i[11];
                flush_dcache_wbuffer_arb_o = fence_t_i[12];
                flush_dcache_fifo_o        = fence_t_i[13];
                fence_active_d             = fence_t_i[4];
            end

            // Trap entry and return take their own PC
            if (event_i[EV_EXCEPTION] || event_i[EV_ERET]) begin
                set_pc_commit_o        = 1'b0;
                flush_if_o             = 1'b1;
                flush_unissued_instr_o = 1'b1;
                flush_id_o             = 1'b1;
                flush_ex_o             = 1'b1;
                flush_bp_o             = 1'b1;
            end
        end

        // --------------------
        // Fence tracking
        // --------------------
        if (fence_active_q && flush_dcache_ack_i) begin
            fence_active_d = 1'b0;
        end else if (fence_active_q) begin
            // Hold the request until the cache answers
            flush_dcache = 1'b1;
        end
    end

    // Core stalls on a CSR request or an open fence
    assign halt_o = halt_csr_i || fence_active_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fence_active_q <= 1'b0;
            flush_dcache_o <= 1'b0;
        end else begin
            fence_active_q <= fence_active_d;
            flush_dcache_o <= flush_dcache;
        end
    end

endmodule

`default_nettype wire

//--- logic/dcache_flush_engine.sv
`default_nettype none

module dcache_flush_engine import flush_pkg::*; (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic flush_i,
    output logic ack_o,
    output logic busy_o
);

    typedef enum logic [1:0] {
        IDLE,
        WALK,
        ACK,
        DRAIN
    } state_e;

    state_e state_q;
    logic [DCACHE_IDX_W-1:0] line_q;

    // Ack is a single cycle, taken from the state register
    assign ack_o  = (state_q == ACK);
    assign busy_o = (state_q == WALK) || (state_q == ACK);

    // --------------------
    // Line walk
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            line_q  <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    line_q <= '0;
                    if (flush_i) state_q <= WALK;
                end
                WALK: begin
                    // One line per cycle
                    line_q <= line_q + 1'b1;
                    if (line_q == DCACHE_IDX_W'(DCACHE_LINES - 1)) state_q <= ACK;
                end
                ACK:     state_q <= DRAIN;
                // Wait for the request to drop before rearming
                DRAIN:   if (!flush_i) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/flush_subsystem.sv
`default_nettype none

module flush_subsystem import flush_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 commit_valid_i,
    input  logic [OP_W-1:0]      commit_op_i,
    input  logic [FENCE_T_W-1:0] commit_fence_t_i,
    input  logic                 halt_csr_i,
    output logic                 commit_ready_o,
    output logic                 set_pc_commit_o,
    output logic                 flush_if_o,
    output logic                 flush_unissued_instr_o,
    output logic                 flush_id_o,
    output logic                 flush_ex_o,
    output logic                 flush_bp_o,
    output logic                 flush_icache_o,
    output logic                 flush_tlb_o,
    output logic                 flush_dcache_lfsr_o,
    output logic                 flush_icache_lfsr_o,
    output logic                 flush_tlb_plru_tree_o,
    output logic                 flush_dcache_mem_arb_o,
    output logic                 flush_dcache_wbuffer_arb_o,
    output logic                 flush_dcache_fifo_o,
    output logic                 flush_dcache_o,
    output logic                 halt_o,
    output logic                 dcache_busy_o
);

    // --------------------
    // Internal nets
    // --------------------
    logic                 push;
    logic [EV_W-1:0]      push_event;
    logic [FENCE_T_W-1:0] push_mask;
    logic                 full;
    logic [EV_W-1:0]      head_event;
    logic [FENCE_T_W-1:0] head_mask;
    logic                 head_valid;
    logic                 dcache_ack;

    // Commit side stalls on a full queue
    assign commit_ready_o = !full;

    commit_event_decoder i_commit_event_decoder (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .commit_valid_i   (commit_valid_i),
        .commit_op_i      (commit_op_i),
        .commit_fence_t_i (commit_fence_t_i),
        .full_i           (full),
        .push_o           (push),
        .event_o          (push_event),
        .mask_o           (push_mask)
    );

    flush_event_queue i_flush_event_queue (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .push_i       (push),
        .event_i      (push_event),
        .mask_i       (push_mask),
        .halt_i       (halt_o),
        .head_event_o (head_event),
        .head_mask_o  (head_mask),
        .head_valid_o (head_valid),
        .full_o       (full)
    );

    flush_controller i_flush_controller (
        .clk_i                      (clk_i),
        .rst_ni                     (rst_ni),
        .event_valid_i              (head_valid),
        .event_i                    (head_event),
        .fence_t_i                  (head_mask),
        .flush_dcache_ack_i         (dcache_ack),
        .halt_csr_i                 (halt_csr_i),
        .set_pc_commit_o            (set_pc_commit_o),
        .flush_if_o                 (flush_if_o),
        .flush_unissued_instr_o     (flush_unissued_instr_o),
        .flush_id_o                 (flush_id_o),
        .flush_ex_o                 (flush_ex_o),
        .flush_bp_o                 (flush_bp_o),
        .flush_icache_o             (flush_icache_o),
        .flush_tlb_o                (flush_tlb_o),
        .flush_dcache_lfsr_o        (flush_dcache_lfsr_o),
        .flush_icache_lfsr_o        (flush_icache_lfsr_o),
        .flush_tlb_plru_tree_o      (flush_tlb_plru_tree_o),
        .flush_dcache_mem_arb_o     (flush_dcache_mem_arb_o),
        .flush_dcache_wbuffer_arb_o (flush_dcache_wbuffer_arb_o),
        .flush_dcache_fifo_o        (flush_dcache_fifo_o),
        .flush_dcache_o             (flush_dcache_o),
        .halt_o                     (halt_o)
    );

    // Stand-in for the data cache
    dcache_flush_engine i_dcache_flush_engine (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_dcache_o),
        .ack_o   (dcache_ack),
        .busy_o  (dcache_busy_o)
    );

endmodule

`default_nettype wire

//--- verification/flush_assert.sv
`default_nettype none

module flush_assert import flush_pkg::*; (
    input logic            clk_i,
    input logic            rst_ni,
    input logic            event_valid_i,
    input logic [EV_W-1:0] event_i,
    input logic            ack_i,
    input logic            flush_dcache_i,
    input logic            halt_i,
    input logic [13:0]     strobes_i
);
    timeunit 1ns;
    timeprecision 1ns;

    // Failed assertions, read by the testbench top
    int unsigned fail_cnt = 0;

    // Nothing flushes while the core is halted
    quiet_in_halt: assert property (@(posedge clk_i) disable iff (!rst_ni)
        halt_i |-> (strobes_i == '0))
        else begin
            fail_cnt++;
            $error("flush strobe raised while halt_o is high");
        end

    // An open data cache flush always halts the core
    halt_with_dcache: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_dcache_i |-> halt_i)
        else begin
            fail_cnt++;
            $error("flush_dcache_o high without halt_o");
        end

    // Request drops only one cycle after the cache answered
    drop_after_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $fell(flush_dcache_i) |-> $past(ack_i))
        else begin
            fail_cnt++;
            $error("flush_dcache_o fell without an acknowledge");
        end

    // Queue head must be one-hot
    head_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        event_valid_i |-> $onehot(event_i))
        else begin
            fail_cnt++;
            $error("head event is not one-hot");
        end

endmodule

// Attach to every controller instance
bind flush_controller flush_assert i_flush_assert (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .event_valid_i  (event_valid_i),
    .event_i        (event_i),
    .ack_i          (flush_dcache_ack_i),
    .flush_dcache_i (flush_dcache_o),
    .halt_i         (halt_o),
    .strobes_i      ({flush_dcache_fifo_o, flush_dcache_wbuffer_arb_o,
                      flush_dcache_mem_arb_o, flush_tlb_plru_tree_o,
                      flush_icache_lfsr_o, flush_dcache_lfsr_o, flush_tlb_o,
                      flush_icache_o, flush_bp_o, flush_ex_o, flush_id_o,
                      flush_unissued_instr_o, flush_if_o, set_pc_commit_o})
);

`default_nettype wire

//--- verification/flush_checker.sv
`default_nettype none

module flush_checker import flush_pkg::*; (
    input logic        clk_i,
    input logic        rst_ni,
    input int unsigned num_tests_i,
    input logic        commit_valid_i,
    input logic        commit_ready_i,
    input logic        halt_csr_i,
    input logic [13:0] strobes_i,
    input logic        flush_dcache_i,
    input logic        halt_i,
    input logic        dcache_busy_i
);
    timeunit 1ns;
    timeprecision 1ns;

    int unsigned accepted;
    int unsigned pops;
    int unsigned tests_done;
    int unsigned errors;
    int unsigned checks;
    int unsigned fence_cycles;
    int unsigned busy_cycles;
    logic        fence_open;
    logic        test_bad;

    // --------------------
    // Expected strobes
    // --------------------
    // Bit 0 set_pc, 1 if, 2 unissued, 3 id, 4 ex, 5 bp, 6 icache, 7 tlb, 8..13 fence.t extras
    function automatic logic [13:0] expect_strobes(input logic [OP_W-1:0] op,
                                                   input logic [FENCE_T_W-1:0] m);
        logic [13:0] e;
        e = '0;
        case (op)
            OP_BRANCH_MISS: e = 14'h0006;
            // set_pc group
            OP_FENCE, OP_CSR_WR: e = 14'h001f;
            OP_FENCE_I: e = 14'h005f;
            OP_SFENCE: e = 14'h009f;
            // Traps flush bp and never set_pc
            OP_EXC, OP_ERET: e = 14'h003e;
            OP_FENCE_T: begin
                e[0]    = 1'b1;
                e[4:1]  = m[3:0];
                e[6]    = m[5];
                e[7]    = m[6];
                e[5]    = m[7];
                e[13:8] = m[13:8];
            end
            default: e = '0;
        endcase
        return e;
    endfunction

    function automatic string strobe_name(input int b);
        case (b)
            0:  return "set_pc_commit_o";
            1:  return "flush_if_o";
            2:  return "flush_unissued_instr_o";
            3:  return "flush_id_o";
            4:  return "flush_ex_o";
            5:  return "flush_bp_o";
            6:  return "flush_icache_o";
            7:  return "flush_tlb_o";
            8:  return "flush_dcache_lfsr_o";
            9:  return "flush_icache_lfsr_o";
            10: return "flush_tlb_plru_tree_o";
            11: return "flush_dcache_mem_arb_o";
            12: return "flush_dcache_wbuffer_arb_o";
            default: return "flush_dcache_fifo_o";
        endcase
    endfunction

    task automatic report_value(input string name, input int unsigned exp,
                                input int unsigned act);
        errors++;
        test_bad = 1'b1;
        $display("Error at %0t ns: %s expected %0d got %0d", $time, name, exp, act);
    endtask

    task automatic close_test(input int unsigned idx);
        tests_done++;
        $display("Test %0d op %0d mask %h %s at %0t ns", idx, flush_tb.op_tbl[idx],
                 flush_tb.mask_tbl[idx], test_bad ? "failed" : "ok", $time);
        test_bad = 1'b0;
    endtask

    // --------------------
    // Per-cycle watch
    // --------------------
    always @(negedge clk_i) begin : watch
        int unsigned          pending;
        logic [13:0]          exp;
        logic [OP_W-1:0]      op;
        logic [FENCE_T_W-1:0] m;
        if (!rst_ni) begin
            accepted     = 0;
            pops         = 0;
            tests_done   = 0;
            errors       = 0;
            checks       = 0;
            fence_cycles = 0;
            busy_cycles  = 0;
            fence_open   = 1'b0;
            test_bad     = 1'b0;
        end else begin
            // Ready low exactly when decoder plus queue hold QUEUE_DEPTH events
            pending = accepted - pops;
            checks++;
            if (commit_ready_i !== (pending < QUEUE_DEPTH))
                report_value("commit_ready_o", pending < QUEUE_DEPTH, commit_ready_i);
            if (commit_valid_i && commit_ready_i) accepted++;
            if (halt_csr_i && halt_i !== 1'b1) report_value("halt_o", 1, halt_i);

            // Open fence holds the request and halt until the ack
            if (fence_open) begin
                if (flush_dcache_i === 1'b1) begin
                    fence_cycles++;
                    if (dcache_busy_i === 1'b1) busy_cycles++;
                    if (halt_i !== 1'b1) report_value("halt_o", 1, halt_i);
                    if (fence_cycles > DCACHE_LINES + 2) begin
                        $display("Data cache flush of test %0d was never acknowledged",
                                 pops - 1);
                        errors++;
                        test_bad   = 1'b1;
                        fence_open = 1'b0;
                        close_test(pops - 1);
                    end
                end else begin
                    // Ack comes DCACHE_LINES+1 cycles after the rise and the request falls one later
                    checks++;
                    if (fence_cycles != DCACHE_LINES + 2)
                        report_value("flush_dcache_o high cycles", DCACHE_LINES + 2,
                                     fence_cycles);
                    // Engine busy over the line walk and the ack cycle
                    if (busy_cycles != DCACHE_LINES + 1)
                        report_value("dcache_busy_o high cycles", DCACHE_LINES + 1,
                                     busy_cycles);
                    if (dcache_busy_i !== 1'b0) report_value("dcache_busy_o", 0, dcache_busy_i);
                    if (halt_i && !halt_csr_i) report_value("halt_o", 0, halt_i);
                    fence_open = 1'b0;
                    close_test(pops - 1);
                end
            end else if (dcache_busy_i !== 1'b0) begin
                // Engine stays idle outside a fence
                report_value("dcache_busy_o", 0, dcache_busy_i);
            end

            if (|strobes_i) begin
                if (halt_i) begin
                    report_value("flush strobes", 0, strobes_i);
                end else if (pops >= num_tests_i) begin
                    $display("Strobe cycle at %0t ns with no committed instruction left",
                             $time);
                    errors++;
                end else begin
                    op  = flush_tb.op_tbl[pops];
                    m   = flush_tb.mask_tbl[pops];
                    exp = expect_strobes(op, m);
                    for (int b = 0; b < 14; b++) begin
                        checks++;
                        if (strobes_i[b] !== exp[b])
                            report_value(strobe_name(b), exp[b], strobes_i[b]);
                    end
                    if (op == OP_FENCE || op == OP_FENCE_I || (op == OP_FENCE_T && m[4])) begin
                        fence_open   = 1'b1;
                        fence_cycles = 0;
                        busy_cycles  = 0;
                    end else begin
                        close_test(pops);
                    end
                    pops++;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/flush_tb.sv
`default_nettype none

module flush_tb import flush_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ns;

    localparam int NUM_TESTS       = 17;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (DCACHE_LINES + 20);

    logic                 clk;
    logic                 rst_n;
    logic                 commit_valid;
    logic [OP_W-1:0]      commit_op;
    logic [FENCE_T_W-1:0] commit_fence_t;
    logic                 halt_csr;
    logic                 commit_ready;
    logic [13:0]          strobes;
    logic                 flush_dcache;
    logic                 halt;
    logic                 dcache_busy;

    // --------------------
    // Stimulus table
    // --------------------
    // Entries 9 to 12 commit under a CSR halt
    logic [OP_W-1:0] op_tbl [NUM_TESTS] = '{
        OP_BRANCH_MISS, OP_FENCE, OP_CSR_WR, OP_FENCE_T, OP_EXC, OP_SFENCE,
        OP_FENCE_I, OP_ERET, OP_FENCE_T, OP_BRANCH_MISS, OP_FENCE, OP_EXC,
        OP_CSR_WR, OP_ERET, OP_FENCE_T, OP_SFENCE, OP_BRANCH_MISS
    };
    // Forced mask bits with random bits ORed in at start
    logic [FENCE_T_W-1:0] mask_tbl [NUM_TESTS] = '{
        14'h0, 14'h0, 14'h0, 14'h0, 14'h0, 14'h0, 14'h0, 14'h0, 14'h0010,
        14'h0, 14'h0, 14'h0, 14'h0, 14'h0, 14'h0, 14'h0, 14'h0
    };
    logic halt_tbl [NUM_TESTS] = '{
        1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
        1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0
    };

    int unsigned lcg_state = 32'd62185;

    // 32-bit LCG with the mask taken from the upper middle bits
    function automatic logic [FENCE_T_W-1:0] lcg_mask();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[29:16];
    endfunction

    // One commit held back while the queue is full
    task automatic commit_entry(input int k);
        while (!commit_ready) begin
            // A stalled commit side releases the CSR halt so the queue drains
            halt_csr = 1'b0;
            @(posedge clk);
            #2;
        end
        halt_csr       = halt_tbl[k];
        commit_valid   = 1'b1;
        commit_op      = op_tbl[k];
        commit_fence_t = mask_tbl[k];
        @(posedge clk);
        #2;
        commit_valid = 1'b0;
        commit_op    = OP_NONE;
    endtask

    always #20 clk = ~clk;

    flush_subsystem i_flush_subsystem (
        .clk_i                      (clk),
        .rst_ni                     (rst_n),
        .commit_valid_i             (commit_valid),
        .commit_op_i                (commit_op),
        .commit_fence_t_i           (commit_fence_t),
        .halt_csr_i                 (halt_csr),
        .commit_ready_o             (commit_ready),
        .set_pc_commit_o            (strobes[0]),
        .flush_if_o                 (strobes[1]),
        .flush_unissued_instr_o     (strobes[2]),
        .flush_id_o                 (strobes[3]),
        .flush_ex_o                 (strobes[4]),
        .flush_bp_o                 (strobes[5]),
        .flush_icache_o             (strobes[6]),
        .flush_tlb_o                (strobes[7]),
        .flush_dcache_lfsr_o        (strobes[8]),
        .flush_icache_lfsr_o        (strobes[9]),
        .flush_tlb_plru_tree_o      (strobes[10]),
        .flush_dcache_mem_arb_o     (strobes[11]),
        .flush_dcache_wbuffer_arb_o (strobes[12]),
        .flush_dcache_fifo_o        (strobes[13]),
        .flush_dcache_o             (flush_dcache),
        .halt_o                     (halt),
        .dcache_busy_o              (dcache_busy)
    );

    flush_checker i_flush_checker (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .num_tests_i    (NUM_TESTS),
        .commit_valid_i (commit_valid),
        .commit_ready_i (commit_ready),
        .halt_csr_i     (halt_csr),
        .strobes_i      (strobes),
        .flush_dcache_i (flush_dcache),
        .halt_i         (halt),
        .dcache_busy_i  (dcache_busy)
    );

    // --------------------
    // Main sequence
    // --------------------
    initial begin : stimulus
        int unsigned asrt_fails;
        clk            = 1'b0;
        rst_n          = 1'b0;
        commit_valid   = 1'b0;
        commit_op      = OP_NONE;
        commit_fence_t = '0;
        halt_csr       = 1'b0;
        // Random bits on every mask and never a zero fence.t mask
        for (int k = 0; k < NUM_TESTS; k++) begin
            mask_tbl[k] = mask_tbl[k] | lcg_mask();
            if (op_tbl[k] == OP_FENCE_T && mask_tbl[k] == '0) mask_tbl[k][0] = 1'b1;
        end
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;
        for (int k = 0; k < NUM_TESTS; k++) begin
            commit_entry(k);
        end
        halt_csr = 1'b0;
        while (i_flush_checker.tests_done < NUM_TESTS) @(posedge clk);
        // A few idle cycles to catch stray strobes
        repeat (4) @(posedge clk);
        asrt_fails = i_flush_subsystem.i_flush_controller.i_flush_assert.fail_cnt;
        $display("Tests %0d of %0d, checks %0d, errors %0d, assertion failures %0d",
                 i_flush_checker.tests_done, NUM_TESTS, i_flush_checker.checks,
                 i_flush_checker.errors, asrt_fails);
        if (i_flush_checker.errors == 0 && asrt_fails == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    // Upper bound on run length
    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the tests did not complete",
                 WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- flush_subsystem.f
logic/flush_pkg.sv
logic/commit_event_decoder.sv
logic/flush_event_queue.sv
logic/flush_controller.sv
logic/dcache_flush_engine.sv
logic/flush_subsystem.sv
verification/flush_assert.sv
verification/flush_checker.sv
verification/flush_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the flush subsystem testbench with Verilator, run it and search for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module flush_tb \
    -f flush_subsystem.f --Mdir obj_dir &&
    ./obj_dir/Vflush_tb +verilator+error+limit+1000 | tee /dev/stderr |
    grep -F "TEST RESULT: PASS" > /dev/null &&
    echo "Simulation passed" ||
    { echo "Simulation failed"; exit 1; }
